/* src/eval_pkg.sv */
package eval_pkg;

   typedef logic [3:0] piece_t;           // Square code, bit 3 set for black
   typedef logic [255:0] board_t;         // 64 squares, a1 in the low nibble
   typedef logic [31:0] rank_t;           // One rank of 8 squares
   typedef logic signed [15:0] eval_t;    // Centipawns, positive favours white
   typedef logic signed [23:0] sum_t;     // MG and EG accumulators
   typedef logic [31:0] material_t;       // Material total of one side
   typedef logic [6:0] count_t;           // Piece count
   typedef logic [5:0] phase_t;           // Clamped phase 0..62
   typedef logic signed [47:0] calc_t;    // Taper fixed-point products

   localparam int SCAN_CYCLES = 8;        // One rank per cycle
   localparam int TAPER_LATENCY = 4;      // Taper pipe depth
   localparam int BLACK_BIT = 3;          // Colour bit in piece_t

   typedef logic [$clog2(SCAN_CYCLES)-1:0] rank_idx_t;
   typedef logic [$clog2(TAPER_LATENCY):0] drain_cnt_t;

   // Square codes
   localparam piece_t EMPTY = 4'd0;
   localparam piece_t W_PAWN = 4'd1;
   localparam piece_t W_KNIGHT = 4'd2;
   localparam piece_t W_BISHOP = 4'd3;
   localparam piece_t W_ROOK = 4'd4;
   localparam piece_t W_QUEEN = 4'd5;
   localparam piece_t W_KING = 4'd6;
   localparam piece_t B_PAWN = 4'd9;
   localparam piece_t B_KNIGHT = 4'd10;
   localparam piece_t B_BISHOP = 4'd11;
   localparam piece_t B_ROOK = 4'd12;
   localparam piece_t B_QUEEN = 4'd13;
   localparam piece_t B_KING = 4'd14;

   // Indexed by piece kind (code bits 2:0), kinds 0 and 7 unused
   localparam eval_t MG_VALUE [8] = '{0, 82, 337, 365, 477, 1025, 0, 0};
   localparam eval_t EG_VALUE [8] = '{0, 94, 281, 297, 512, 936, 0, 0};
   localparam material_t MAT_VALUE [8] = '{0, 100, 300, 325, 500, 975, 0, 0};

   localparam phase_t PHASE_MAX = 6'd62;  // Full board phase cap
   localparam calc_t RECIP_62 = 48'sd16912; // 2^20 / 62, truncated
   localparam int FRAC_BITS = 20;         // Fraction bits of RECIP_62

   typedef enum logic [2:0]
   {
      st_idle,                            // Board register tracks board_in
      st_wait_attack,                     // Board captured, attack maps pending
      st_scan,                            // Material scan running
      st_drain,                           // Taper pipe settling
      st_hold                             // Result valid until clear_eval
   } ctrl_state_t;

endpackage

/* src/eval_ctrl.sv */
`timescale 1ns/1ns

module eval_ctrl
   (
   input  logic clk,
   input  logic reset,
   input  logic board_valid,              // Capture on rising edge
   input  logic is_attacking_done,        // Level from attack generator
   input  logic scan_done,                // Level from material_scan
   input  logic drain_expired,            // Pulse from latency_timer
   input  logic clear_eval,               // Releases the held result
   output logic board_load,               // Board register enable
   output logic scan_start,               // One-cycle pulse
   output logic drain_start,              // One-cycle pulse
   output logic eval_valid                // High in st_hold
   );

   eval_pkg::ctrl_state_t state;
   logic board_valid_r;                   // Previous board_valid for edge detect

   assign board_load = (state == eval_pkg::st_idle);  // Track board_in while idle
   assign eval_valid = (state == eval_pkg::st_hold);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state <= eval_pkg::st_idle;
         board_valid_r <= 1'b0;
         scan_start <= 1'b0;
         drain_start <= 1'b0;
      end
      else
      begin
         board_valid_r <= board_valid;
         scan_start <= 1'b0;              // Pulses default low
         drain_start <= 1'b0;
         case (state)
            eval_pkg::st_idle:
            begin
               if (board_valid && !board_valid_r)    // Rising edge only
                  state <= eval_pkg::st_wait_attack; // Board register now frozen
            end
            eval_pkg::st_wait_attack:
            begin
               if (is_attacking_done)
               begin
                  scan_start <= 1'b1;
                  state <= eval_pkg::st_scan;
               end
            end
            eval_pkg::st_scan:
            begin
               // scan_done from the last board is still high while scan_start is
               if (scan_done && !scan_start)
               begin
                  drain_start <= 1'b1;
                  state <= eval_pkg::st_drain;
               end
            end
            eval_pkg::st_drain:
            begin
               if (drain_expired)
                  state <= eval_pkg::st_hold; // Taper output settled
            end
            eval_pkg::st_hold:
            begin
               if (clear_eval)
                  state <= eval_pkg::st_idle;
            end
            default:
            begin
               state <= eval_pkg::st_idle;
            end
         endcase
      end
   end

endmodule

/* src/latency_timer.sv */
`timescale 1ns/1ns

module latency_timer
   (
   input  logic clk,
   input  logic reset,
   input  logic drain_start,              // Loads the counter
   output logic drain_expired             // One-cycle pulse at the end
   );

   eval_pkg::drain_cnt_t count;           // Zero when idle

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         count <= '0;
         drain_expired <= 1'b0;
      end
      else
      begin
         drain_expired <= (count == eval_pkg::drain_cnt_t'(1)); // Last step
         if (drain_start)
            count <= eval_pkg::drain_cnt_t'(eval_pkg::TAPER_LATENCY - 1);
         else if (count != '0)
            count <= count - 1'b1;
      end
   end

endmodule

/* src/material_scan.sv */
`timescale 1ns/1ns

module material_scan
   (
   input  logic clk,
   input  logic reset,
   input  logic scan_start,               // Clears sums, starts at rank 1
   input  eval_pkg::board_t board,        // Captured board, stable during scan
   output logic scan_done,                // Held until next scan_start
   output eval_pkg::sum_t mg_sum,         // White minus black, middlegame
   output eval_pkg::sum_t eg_sum,         // White minus black, endgame
   output eval_pkg::count_t piece_count,  // Occupied squares
   output eval_pkg::material_t material_white,
   output eval_pkg::material_t material_black,
   output logic insufficient_material
   );

   logic busy;                            // Scan in progress
   eval_pkg::rank_idx_t rank_idx;         // Rank being summed
   eval_pkg::rank_t rank_sq;              // Squares of the current rank
   logic last_rank;
   logic insuff_nxt;

   // Per-rank lookup results
   eval_pkg::sum_t rank_mg;
   eval_pkg::sum_t rank_eg;
   eval_pkg::material_t rank_mat_w;
   eval_pkg::material_t rank_mat_b;
   eval_pkg::count_t rank_occ;
   eval_pkg::count_t rank_pawn_w;
   eval_pkg::count_t rank_pawn_b;
   eval_pkg::count_t rank_major_w;        // Rooks and queens
   eval_pkg::count_t rank_major_b;
   eval_pkg::count_t rank_minor_w;        // Knights and bishops
   eval_pkg::count_t rank_minor_b;

   // Running per-side counts
   eval_pkg::count_t pawn_w;
   eval_pkg::count_t pawn_b;
   eval_pkg::count_t major_w;
   eval_pkg::count_t major_b;
   eval_pkg::count_t minor_w;
   eval_pkg::count_t minor_b;

   assign rank_sq = board[rank_idx * $bits(eval_pkg::rank_t) +: $bits(eval_pkg::rank_t)];
   assign last_rank = (rank_idx == eval_pkg::rank_idx_t'(eval_pkg::SCAN_CYCLES - 1));

   always_comb
   begin : rank_lookup
      eval_pkg::piece_t sq;
      logic [2:0] kind;
      rank_mg = '0;
      rank_eg = '0;
      rank_mat_w = '0;
      rank_mat_b = '0;
      rank_occ = '0;
      rank_pawn_w = '0;
      rank_pawn_b = '0;
      rank_major_w = '0;
      rank_major_b = '0;
      rank_minor_w = '0;
      rank_minor_b = '0;
      for (int i = 0; i < 8; i++)
      begin
         sq = rank_sq[i * $bits(eval_pkg::piece_t) +: $bits(eval_pkg::piece_t)];
         kind = sq[2:0];                  // Kind without colour
         if (sq != eval_pkg::EMPTY)
            rank_occ = rank_occ + 1'b1;
         if (sq[eval_pkg::BLACK_BIT])
         begin
            rank_mg = rank_mg - eval_pkg::sum_t'(eval_pkg::MG_VALUE[kind]);
            rank_eg = rank_eg - eval_pkg::sum_t'(eval_pkg::EG_VALUE[kind]);
            rank_mat_b = rank_mat_b + eval_pkg::MAT_VALUE[kind];
            if (kind == eval_pkg::B_PAWN[2:0])
               rank_pawn_b = rank_pawn_b + 1'b1;
            if (kind == eval_pkg::B_ROOK[2:0] || kind == eval_pkg::B_QUEEN[2:0])
               rank_major_b = rank_major_b + 1'b1;
            if (kind == eval_pkg::B_KNIGHT[2:0] || kind == eval_pkg::B_BISHOP[2:0])
               rank_minor_b = rank_minor_b + 1'b1;
         end
         else
         begin
            rank_mg = rank_mg + eval_pkg::sum_t'(eval_pkg::MG_VALUE[kind]); // Empty adds 0
            rank_eg = rank_eg + eval_pkg::sum_t'(eval_pkg::EG_VALUE[kind]);
            rank_mat_w = rank_mat_w + eval_pkg::MAT_VALUE[kind];
            if (kind == eval_pkg::W_PAWN[2:0])
               rank_pawn_w = rank_pawn_w + 1'b1;
            if (kind == eval_pkg::W_ROOK[2:0] || kind == eval_pkg::W_QUEEN[2:0])
               rank_major_w = rank_major_w + 1'b1;
            if (kind == eval_pkg::W_KNIGHT[2:0] || kind == eval_pkg::W_BISHOP[2:0])
               rank_minor_w = rank_minor_w + 1'b1;
         end
      end
   end

   // Decided on the totals including the last rank
   assign insuff_nxt = (pawn_w + rank_pawn_w == '0) && (pawn_b + rank_pawn_b == '0) &&
                       (major_w + rank_major_w == '0) && (major_b + rank_major_b == '0) &&
                       (minor_w + rank_minor_w <= 7'd1) && (minor_b + rank_minor_b <= 7'd1);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy <= 1'b0;
         rank_idx <= '0;
         scan_done <= 1'b0;
         insufficient_material <= 1'b0;
      end
      else if (scan_start)
      begin
         busy <= 1'b1;
         rank_idx <= '0;                  // a1 rank first
         scan_done <= 1'b0;
         insufficient_material <= 1'b0;
      end
      else if (busy)
      begin
         rank_idx <= rank_idx + 1'b1;
         if (last_rank)
         begin
            busy <= 1'b0;
            scan_done <= 1'b1;
            insufficient_material <= insuff_nxt;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (scan_start)
      begin
         mg_sum <= '0;
         eg_sum <= '0;
         piece_count <= '0;
         material_white <= '0;
         material_black <= '0;
         pawn_w <= '0;
         pawn_b <= '0;
         major_w <= '0;
         major_b <= '0;
         minor_w <= '0;
         minor_b <= '0;
      end
      else if (busy)                      // Hold once scan is done
      begin
         mg_sum <= mg_sum + rank_mg;
         eg_sum <= eg_sum + rank_eg;
         piece_count <= piece_count + rank_occ;
         material_white <= material_white + rank_mat_w;
         material_black <= material_black + rank_mat_b;
         pawn_w <= pawn_w + rank_pawn_w;
         pawn_b <= pawn_b + rank_pawn_b;
         major_w <= major_w + rank_major_w;
         major_b <= major_b + rank_major_b;
         minor_w <= minor_w + rank_minor_w;
         minor_b <= minor_b + rank_minor_b;
      end
   end

endmodule

/* src/taper_pipe.sv */
`timescale 1ns/1ns

module taper_pipe
   (
   input  logic clk,
   input  eval_pkg::sum_t mg_sum,
   input  eval_pkg::sum_t eg_sum,
   input  eval_pkg::count_t piece_count,  // Becomes the phase
   output eval_pkg::eval_t eval           // TAPER_LATENCY cycles after inputs
   );

   // Stage 1
   eval_pkg::sum_t mg_s1;
   eval_pkg::sum_t eg_s1;
   eval_pkg::phase_t phase_s1;
   // Stage 2
   eval_pkg::calc_t blend_s2;             // mg*phase + eg*(62-phase)
   // Stage 3
   eval_pkg::calc_t prod_s3;              // Scaled by 2^20/62

   always_ff @(posedge clk)
   begin
      mg_s1 <= mg_sum;
      eg_s1 <= eg_sum;
      if (piece_count > eval_pkg::count_t'(eval_pkg::PHASE_MAX))
         phase_s1 <= eval_pkg::PHASE_MAX; // Clamp at 62
      else
         phase_s1 <= eval_pkg::phase_t'(piece_count);
   end

   always_ff @(posedge clk)
   begin
      blend_s2 <= eval_pkg::calc_t'(mg_s1) * eval_pkg::calc_t'(phase_s1) +
                  eval_pkg::calc_t'(eg_s1) *
                  (eval_pkg::calc_t'(eval_pkg::PHASE_MAX) - eval_pkg::calc_t'(phase_s1));
   end

   always_ff @(posedge clk)
   begin
      prod_s3 <= blend_s2 * eval_pkg::RECIP_62; // Divide by 62 as multiply
   end

   always_ff @(posedge clk)
   begin
      // Signed divide by 2^20 truncates to zero
      eval <= eval_pkg::eval_t'(prod_s3 / (eval_pkg::calc_t'(1) <<< eval_pkg::FRAC_BITS));
   end

endmodule

/* src/eval_top.sv */
`timescale 1ns/1ns

module eval_top
   (
   input  logic clk,
   input  logic reset,
   input  logic board_valid,              // Rising edge captures board_in
   input  eval_pkg::board_t board_in,
   input  logic is_attacking_done,        // Level, starts the scan
   input  logic clear_eval,               // Ends the result hold
   output eval_pkg::eval_t eval,
   output logic eval_valid,
   output eval_pkg::material_t material_white,
   output eval_pkg::material_t material_black,
   output logic insufficient_material
   );

   eval_pkg::board_t board;               // Captured board
   logic board_load;
   logic scan_start;
   logic scan_done;
   logic drain_start;
   logic drain_expired;
   eval_pkg::sum_t mg_sum;
   eval_pkg::sum_t eg_sum;
   eval_pkg::count_t piece_count;

   // Follows board_in while idle, frozen from the capture edge on
   always_ff @(posedge clk)
   begin
      if (board_load)
         board <= board_in;
   end

   eval_ctrl ctrl_i
   (
      .clk               (clk),
      .reset             (reset),
      .board_valid       (board_valid),
      .is_attacking_done (is_attacking_done),
      .scan_done         (scan_done),
      .drain_expired     (drain_expired),
      .clear_eval        (clear_eval),
      .board_load        (board_load),
      .scan_start        (scan_start),
      .drain_start       (drain_start),
      .eval_valid        (eval_valid)
   );

   latency_timer timer_i
   (
      .clk           (clk),
      .reset         (reset),
      .drain_start   (drain_start),
      .drain_expired (drain_expired)
   );

   material_scan scan_i
   (
      .clk                   (clk),
      .reset                 (reset),
      .scan_start            (scan_start),
      .board                 (board),
      .scan_done             (scan_done),
      .mg_sum                (mg_sum),
      .eg_sum                (eg_sum),
      .piece_count           (piece_count),
      .material_white        (material_white),
      .material_black        (material_black),
      .insufficient_material (insufficient_material)
   );

   // Free running, settles during st_drain
   taper_pipe taper_i
   (
      .clk         (clk),
      .mg_sum      (mg_sum),
      .eg_sum      (eg_sum),
      .piece_count (piece_count),
      .eval        (eval)
   );

endmodule

/* dv/eval_checker.sv */
`timescale 1ns/1ns

module eval_checker
   (
   input  logic clk,
   input  logic reset,
   input  logic clear_eval,               // Release of the held result
   input  logic eval_valid,               // High in st_hold
   input  eval_pkg::eval_t eval           // Taper pipe output
   );

   // No result survives a reset cycle
   valid_low_after_reset: assert property (@(posedge clk) reset |=> !eval_valid)
      else $error("eval_valid high on the cycle after reset");

   // Still idle one cycle after reset is released
   valid_low_on_release: assert property (@(posedge clk) $fell(reset) |=> !eval_valid)
      else $error("eval_valid high on the cycle after reset release");

   // Clear sampled in st_hold drops the result next edge
   valid_falls_on_clear: assert property (@(posedge clk) disable iff (reset)
      eval_valid && clear_eval |=> !eval_valid)
      else $error("eval_valid still high one cycle after clear_eval");

   // Hold until released
   valid_held: assert property (@(posedge clk) disable iff (reset)
      eval_valid && !clear_eval |=> eval_valid)
      else $error("eval_valid fell without clear_eval");

   // Score frozen for the whole hold
   eval_stable: assert property (@(posedge clk) disable iff (reset)
      eval_valid && $past(eval_valid) |-> $stable(eval))
      else $error("eval changed while eval_valid stayed high");

endmodule

/* dv/eval_tb.sv */
`timescale 1ns/1ns

module eval_tb;

   localparam int NUM_TESTS = 9;
   localparam int HOLD_CYCLES = 3;        // Result watched this long before clear
   // Drive of is_attacking_done to eval_valid, in edges
   localparam int LATENCY = 1 + (eval_pkg::SCAN_CYCLES + 1) + (eval_pkg::TAPER_LATENCY + 2);

   logic clk;
   logic reset;
   logic board_valid;
   eval_pkg::board_t board_in;
   logic is_attacking_done;
   logic clear_eval;
   eval_pkg::eval_t eval;
   logic eval_valid;
   eval_pkg::material_t material_white;
   eval_pkg::material_t material_black;
   logic insufficient_material;

   eval_pkg::board_t tbl_board [NUM_TESTS]; // Stimulus table
   longint tbl_mat_w [NUM_TESTS];
   longint tbl_mat_b [NUM_TESTS];
   longint tbl_insuff [NUM_TESTS];
   int errors;
   int checks;

   eval_top dut_i
   (
      .clk                   (clk),
      .reset                 (reset),
      .board_valid           (board_valid),
      .board_in              (board_in),
      .is_attacking_done     (is_attacking_done),
      .clear_eval            (clear_eval),
      .eval                  (eval),
      .eval_valid            (eval_valid),
      .material_white        (material_white),
      .material_black        (material_black),
      .insufficient_material (insufficient_material)
   );

   bind eval_top eval_checker checker_i
   (
      .clk        (clk),
      .reset      (reset),
      .clear_eval (clear_eval),
      .eval_valid (eval_valid),
      .eval       (eval)
   );

   always #2 clk = ~clk;                  // 4 ns period

   function automatic eval_pkg::board_t place(eval_pkg::board_t b, int sq, logic [3:0] code);
      b[sq * 4 +: 4] = code;              // Square 0 is a1
      return b;
   endfunction

   function automatic eval_pkg::board_t opening_board();
      eval_pkg::board_t b;
      logic [3:0] back [8];
      back = '{4'd4, 4'd2, 4'd3, 4'd5, 4'd6, 4'd3, 4'd2, 4'd4}; // R N B Q K B N R
      b = '0;
      for (int f = 0; f < 8; f++)
      begin
         b = place(b, f, back[f]);
         b = place(b, 8 + f, 4'd1);       // White pawns
         b = place(b, 48 + f, 4'd9);      // Black pawns
         b = place(b, 56 + f, back[f] | 4'h8);
      end
      return b;
   endfunction

   // Centipawns per piece kind
   function automatic longint piece_score(logic [2:0] kind, bit endgame);
      case (kind)
         3'd1: return endgame ? 94 : 82;
         3'd2: return endgame ? 281 : 337;
         3'd3: return endgame ? 297 : 365;
         3'd4: return endgame ? 512 : 477;
         3'd5: return endgame ? 936 : 1025;
         default: return 0;               // Empty square and king
      endcase
   endfunction

   // Tapered score, quotient rounded toward zero
   function automatic longint expected_eval(eval_pkg::board_t b);
      longint mg;
      longint eg;
      longint phase;
      logic [3:0] sq;
      mg = 0;
      eg = 0;
      phase = 0;
      for (int s = 0; s < 64; s++)
      begin
         sq = b[s * 4 +: 4];
         if (sq != 4'd0)
            phase++;
         mg += sq[3] ? -piece_score(sq[2:0], 0) : piece_score(sq[2:0], 0);
         eg += sq[3] ? -piece_score(sq[2:0], 1) : piece_score(sq[2:0], 1);
      end
      if (phase > 62)
         phase = 62;                      // Clamp
      return ((mg * phase + eg * (62 - phase)) * ((64'sd1 << 20) / 62)) / (64'sd1 << 20);
   endfunction

   task automatic compare(string what, logic signed [63:0] got, logic signed [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic set_entry(int i, eval_pkg::board_t b, longint w, longint bl, longint ins);
      tbl_board[i] = b;
      tbl_mat_w[i] = w;
      tbl_mat_b[i] = bl;
      tbl_insuff[i] = ins;
   endtask

   task automatic build_table();
      eval_pkg::board_t start_pos;
      eval_pkg::board_t kings;
      start_pos = opening_board();
      kings = place(place('0, 4, 4'd6), 60, 4'd14);                     // Ke1, ke8
      set_entry(0, start_pos, 4025, 4025, 0);
      set_entry(1, place(start_pos, 59, 4'd0), 4025, 3050, 0);          // Black queen off
      set_entry(2, place(kings, 0, 4'd4), 500, 0, 0);                   // Ra1
      set_entry(3, place(kings, 63, 4'd12), 0, 500, 0);                 // rh8, negative
      set_entry(4, kings, 0, 0, 1);
      set_entry(5, place(kings, 6, 4'd2), 300, 0, 1);                   // Ng1
      set_entry(6, place(place(kings, 6, 4'd2), 12, 4'd1), 400, 0, 0);  // Plus pawn e2
      set_entry(7, place(place(kings, 5, 4'd3), 57, 4'd10), 325, 300, 1); // Bf1 v nb8
      set_entry(8, place(place(kings, 1, 4'd2), 6, 4'd2), 600, 0, 0);   // Two knights
   endtask

   task automatic run_test(int idx);
      int delay;
      int waited;
      int errors_before;
      eval_pkg::eval_t held;
      errors_before = errors;
      delay = $urandom % 6;               // Attack map delay
      @(posedge clk);
      board_in <= tbl_board[idx];
      board_valid <= 1'b1;
      @(posedge clk);                     // Capture edge
      board_valid <= 1'b0;
      board_in <= {64{4'h5}};             // Late change, must be ignored
      repeat (delay)
      begin
         @(negedge clk);
         compare("eval_valid before attack done", eval_valid, 0);
         @(posedge clk);
      end
      is_attacking_done <= 1'b1;
      board_valid <= 1'b1;                // Edge outside st_idle
      waited = 0;
      do
      begin
         @(posedge clk);
         board_valid <= 1'b0;
         waited++;
         @(negedge clk);
      end while (!eval_valid && waited < 2 * LATENCY);
      if (!eval_valid)
      begin
         errors++;
         $display("Test %0d: eval_valid never rose after attack done", idx);
      end
      else
      begin
         compare("latency", waited, LATENCY);
         compare("eval", eval, expected_eval(tbl_board[idx]));
         compare("material_white", material_white, tbl_mat_w[idx]);
         compare("material_black", material_black, tbl_mat_b[idx]);
         compare("insufficient_material", insufficient_material, tbl_insuff[idx]);
         held = eval;
         repeat (HOLD_CYCLES)
         begin
            @(negedge clk);
            compare("eval_valid in hold", eval_valid, 1);
            compare("eval in hold", eval, held);
         end
         @(posedge clk);
         is_attacking_done <= 1'b0;
         clear_eval <= 1'b1;
         @(posedge clk);
         clear_eval <= 1'b0;
         @(negedge clk);
         compare("eval_valid after clear", eval_valid, 0);
      end
      $display("Test %0d done, %0d mismatches", idx, errors - errors_before);
   endtask

   initial
   begin
      clk = 1'b0;
      reset = 1'b1;
      board_valid = 1'b0;
      board_in = '0;
      is_attacking_done = 1'b0;
      clear_eval = 1'b0;
      errors = 0;
      checks = 0;
      void'($urandom(33642));
      build_table();
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < NUM_TESTS; i++)
         run_test(i);
      $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
      if (errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

   // Each test takes well under 60 cycles
   initial
   begin
      repeat (NUM_TESTS * 60 + 100) @(posedge clk);
      $display("Watchdog expired before all tests finished");
      $display("sim failed");
      $finish;
   end

endmodule

/* build.f */
src/eval_pkg.sv
src/eval_ctrl.sv
src/latency_timer.sv
src/material_scan.sv
src/taper_pipe.sv
src/eval_top.sv
dv/eval_checker.sv
dv/eval_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the evaluator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module eval_tb -f build.f -o eval_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/eval_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
   exit 0
fi
exit 1
